/* src/exu_pkg.sv */
package exu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 4;
    localparam int OPCODE_W   = 7;
    localparam int IMM_W      = 16;

    // -------------------------------------------------------------------------
    // opcodes
    // -------------------------------------------------------------------------
    localparam logic [OPCODE_W-1:0] OP_ADD  = 7'd0;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 7'd1;
    localparam logic [OPCODE_W-1:0] OP_SHL  = 7'd2;   // ones fill from the right
    localparam logic [OPCODE_W-1:0] OP_SHR  = 7'd3;   // ones fill from the left
    localparam logic [OPCODE_W-1:0] OP_MOV  = 7'd4;
    localparam logic [OPCODE_W-1:0] OP_LDL  = 7'd5;
    localparam logic [OPCODE_W-1:0] OP_LDH  = 7'd6;

    localparam logic [OPCODE_W-1:0] OP_CEQ  = 7'd8;
    localparam logic [OPCODE_W-1:0] OP_CLT  = 7'd9;   // unsigned
    localparam logic [OPCODE_W-1:0] OP_CGT  = 7'd10;  // unsigned
    localparam logic [OPCODE_W-1:0] OP_FNOT = 7'd11;

    localparam logic [OPCODE_W-1:0] OP_JMP  = 7'd14;
    localparam logic [OPCODE_W-1:0] OP_BRF  = 7'd15;  // taken when the flag is set

    // -------------------------------------------------------------------------
    // instruction word
    // -------------------------------------------------------------------------
    // both views share opcode, rd and ra in the same bit positions
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rd;
            logic [REG_ADDR_W-1:0] ra;
            logic [REG_ADDR_W-1:0] rb;
            logic [12:0]           spare;
        } r;
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rd;
            logic [REG_ADDR_W-1:0] ra;
            logic                  half;
            logic [IMM_W-1:0]      imm;
        } i;
    } instr_t;

endpackage

/* src/ripple_adder.sv */
`timescale 1ns/1ps

module ripple_adder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             carry_in,
    output logic [WIDTH-1:0] sum
);

    // carry[i] is the carry into bit i
    logic [WIDTH-1:0] carry;

    assign carry[0] = carry_in;

    genvar i;
    generate
        for (i = 0; i < WIDTH; i = i + 1)
        begin : g_cell
            // each cell is a full adder whose sum is the parity of its three inputs
            assign sum[i] = a[i] ^ b[i] ^ carry[i];

            if (i < WIDTH - 1)
            begin : g_carry
                assign carry[i+1] = (a[i] & b[i]) | (a[i] & carry[i]) | (b[i] & carry[i]);
            end
            // the carry out of the top cell is not needed
        end
    endgenerate

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
    import exu_pkg::*;
(
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [DATA_W-1:0]   ra_data,
    input  logic [DATA_W-1:0]   rb_data,
    input  logic [IMM_W-1:0]    imm,
    input  logic                half,
    output logic [DATA_W-1:0]   alu_result,
    output logic                alu_writes
);

    logic              is_sub;
    logic [DATA_W-1:0] add_b;
    logic [DATA_W-1:0] add_sum;
    logic [4:0]        shamt;
    logic [DATA_W-1:0] shl_res;
    logic [DATA_W-1:0] shr_res;
    logic [DATA_W-1:0] load_res;

    // -------------------------------------------------------------------------
    // add and subtract share one adder
    // -------------------------------------------------------------------------
    // subtract is a + ~b + 1
    assign is_sub = (opcode == OP_SUB);
    assign add_b  = is_sub ? ~rb_data : rb_data;

    ripple_adder #(
        .WIDTH    (DATA_W)
    ) i_adder (
        .a        (ra_data),
        .b        (add_b),
        .carry_in (is_sub),
        .sum      (add_sum)
    );

    // -------------------------------------------------------------------------
    // shifts
    // -------------------------------------------------------------------------
    assign shamt = rb_data[4:0];   // amount is rb mod 32

    // invert, shift in zeros, invert back, so the vacated bits end up as ones
    assign shl_res = ~((~ra_data) << shamt);
    assign shr_res = ~((~ra_data) >> shamt);

    // -------------------------------------------------------------------------
    // half-word load
    // -------------------------------------------------------------------------
    // half high puts imm on top and keeps the lower half of ra
    assign load_res = half ? {imm, ra_data[DATA_W-IMM_W-1:0]}
                           : {ra_data[DATA_W-1:IMM_W], imm};

    // -------------------------------------------------------------------------
    // result select
    // -------------------------------------------------------------------------
    always_comb
    begin
        alu_writes = 1'b1;
        case (opcode)
            OP_ADD,
            OP_SUB:
            begin
                alu_result = add_sum;
            end
            OP_SHL:
            begin
                alu_result = shl_res;
            end
            OP_SHR:
            begin
                alu_result = shr_res;
            end
            OP_MOV:
            begin
                alu_result = ra_data;
            end
            OP_LDL,
            OP_LDH:
            begin
                alu_result = load_res;
            end
            default:
            begin
                // flag, branch and unused opcodes write nothing back
                alu_result = '0;
                alu_writes = 1'b0;
            end
        endcase
    end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import exu_pkg::*;
(
    input  logic                clock,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [DATA_W-1:0]   ra_data,
    input  logic [DATA_W-1:0]   rb_data,
    input  logic [DATA_W-1:0]   link_data,
    output logic                cond_flag,
    output logic                branch_taken,
    output logic [DATA_W-1:0]   pc
);

    logic              flag_next;
    logic              taken;
    logic [DATA_W-1:0] pc_next;

    // -------------------------------------------------------------------------
    // condition flag
    // -------------------------------------------------------------------------
    always_comb
    begin
        case (opcode)
            OP_CEQ:  flag_next = (ra_data == rb_data);
            OP_CLT:  flag_next = (ra_data < rb_data);   // operands are unsigned
            OP_CGT:  flag_next = (ra_data > rb_data);
            OP_FNOT: flag_next = ~cond_flag;
            default: flag_next = cond_flag;
        endcase
    end

    // -------------------------------------------------------------------------
    // branch decision
    // -------------------------------------------------------------------------
    // BRF looks at the flag as it stands before this instruction
    assign taken = instr_valid &&
                   ((opcode == OP_JMP) || ((opcode == OP_BRF) && cond_flag));

    assign pc_next = taken ? link_data : pc + DATA_W'(4);

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cond_flag    <= 1'b0;
            branch_taken <= 1'b0;
            pc           <= '0;
        end
        else
        begin
            branch_taken <= taken;   // one cycle pulse
            if (instr_valid)
            begin
                cond_flag <= flag_next;
                pc        <= pc_next;
            end
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import exu_pkg::*;
#(
    parameter int NUM_REGS = 16,
    parameter int LINK_REG = 8
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] ra_addr,
    input  logic [REG_ADDR_W-1:0] rb_addr,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic                  wr_en,
    input  logic [DATA_W-1:0]     wr_data,
    output logic [DATA_W-1:0]     ra_data,
    output logic [DATA_W-1:0]     rb_data,
    output logic [DATA_W-1:0]     link_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_addr < NUM_REGS))   // writes past the top are dropped
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // unimplemented indices read as zero
    assign ra_data = (ra_addr < NUM_REGS) ? regs[ra_addr] : '0;
    assign rb_data = (rb_addr < NUM_REGS) ? regs[rb_addr] : '0;

    generate
        if (LINK_REG < NUM_REGS)
        begin : g_link
            assign link_data = regs[LINK_REG];
        end
        else
        begin : g_no_link
            assign link_data = '0;
        end
    endgenerate

endmodule

/* src/exu_top.sv */
`timescale 1ns/1ps

module exu_top
    import exu_pkg::*;
#(
    parameter int NUM_REGS = 16,
    parameter int LINK_REG = 8
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  instr_t                instr,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_addr,
    output logic [DATA_W-1:0]     wb_data,
    output logic                  cond_flag,
    output logic                  branch_taken,
    output logic [DATA_W-1:0]     pc
);

    logic [OPCODE_W-1:0]   opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;
    logic [IMM_W-1:0]      imm;
    logic                  load_high;
    logic [DATA_W-1:0]     ra_data;
    logic [DATA_W-1:0]     rb_data;
    logic [DATA_W-1:0]     link_data;
    logic [DATA_W-1:0]     alu_result;
    logic                  alu_writes;
    logic                  wr_en;

    // -------------------------------------------------------------------------
    // instruction fields
    // -------------------------------------------------------------------------
    assign opcode = instr.r.opcode;
    assign rd     = instr.r.rd;
    assign ra     = instr.r.ra;
    assign rb     = instr.r.rb;
    assign imm    = instr.i.imm;

    // LDH replaces the upper half and LDL the lower one
    assign load_high = (opcode == OP_LDH);

    assign wr_en = instr_valid && alu_writes;

    reg_file #(
        .NUM_REGS  (NUM_REGS),
        .LINK_REG  (LINK_REG)
    ) i_reg_file (
        .clock     (clock),
        .arst_n    (arst_n),
        .ra_addr   (ra),
        .rb_addr   (rb),
        .wr_addr   (rd),
        .wr_en     (wr_en),
        .wr_data   (alu_result),
        .ra_data   (ra_data),
        .rb_data   (rb_data),
        .link_data (link_data)
    );

    alu i_alu (
        .opcode     (opcode),
        .ra_data    (ra_data),
        .rb_data    (rb_data),
        .imm        (imm),
        .half       (load_high),
        .alu_result (alu_result),
        .alu_writes (alu_writes)
    );

    branch_unit i_branch (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .opcode       (opcode),
        .ra_data      (ra_data),
        .rb_data      (rb_data),
        .link_data    (link_data),
        .cond_flag    (cond_flag),
        .branch_taken (branch_taken),
        .pc           (pc)
    );

    // -------------------------------------------------------------------------
    // write-back report
    // -------------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= wr_en;   // also set for rd beyond NUM_REGS
    end

    always_ff @(posedge clock)
    begin
        if (wr_en)
        begin
            wb_addr <= rd;
            wb_data <= alu_result;
        end
    end

endmodule

/* dv/exu_checker.sv */
`timescale 1ns/1ps

module exu_checker
    import exu_pkg::*;
#(
    parameter int NUM_REGS = 16,
    parameter int LINK_REG = 8
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  instr_valid,
    input  instr_t                instr,
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_addr,
    input  logic [DATA_W-1:0]     wb_data,
    input  logic                  cond_flag,
    input  logic                  branch_taken,
    input  logic [DATA_W-1:0]     pc,
    output int                    value_errors,
    output int                    pulse_errors,
    output int                    wb_count
);

    logic [DATA_W-1:0]     regs [NUM_REGS];
    logic                  flag;
    logic [DATA_W-1:0]     model_pc;
    logic                  exp_wb_valid;
    logic [REG_ADDR_W-1:0] exp_wb_addr;
    logic [DATA_W-1:0]     exp_wb_data;
    logic                  exp_taken;
    logic                  armed = 1'b0;    // nothing to compare before the first edge
    int                    n_value = 0;
    int                    n_pulse = 0;
    int                    n_wb = 0;

    assign value_errors = n_value;
    assign pulse_errors = n_pulse;
    assign wb_count     = n_wb;

    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] idx);
        if (idx < NUM_REGS)
            return regs[idx];
        return '0;
    endfunction

    // ------------------------------------------------------------------------
    // the model updates on every rising edge from the values before the edge
    // ------------------------------------------------------------------------
    always @(posedge clock)
    begin
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] link;
        logic [DATA_W-1:0] res;
        logic [4:0]        sh;
        logic              writes;
        logic              taken;

        armed        = 1'b1;
        exp_wb_valid = 1'b0;
        exp_taken    = 1'b0;
        if (!arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] = '0;
            flag     = 1'b0;
            model_pc = '0;
        end
        else if (instr_valid)
        begin
            a      = read_reg(instr.r.ra);
            b      = read_reg(instr.r.rb);
            link   = '0;
            if (LINK_REG < NUM_REGS)
                link = regs[LINK_REG];
            sh     = b[4:0];
            writes = 1'b1;
            case (instr.r.opcode)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_SHL:  res = (a << sh) | ((32'd1 << sh) - 32'd1);   // ones enter from the right
                OP_SHR:  res = (a >> sh) | ~(32'hffff_ffff >> sh);
                OP_MOV:  res = a;
                OP_LDL:  res = {a[31:16], instr.i.imm};
                OP_LDH:  res = {instr.i.imm, a[15:0]};
                default:
                begin
                    res    = '0;
                    writes = 1'b0;
                end
            endcase
            // the branch sees the flag as it was before this instruction
            taken = (instr.r.opcode == OP_JMP) || ((instr.r.opcode == OP_BRF) && flag);
            case (instr.r.opcode)
                OP_CEQ:  flag = (a == b);
                OP_CLT:  flag = (a < b);
                OP_CGT:  flag = (a > b);
                OP_FNOT: flag = !flag;
                default: flag = flag;
            endcase
            model_pc  = taken ? link : model_pc + 32'd4;
            exp_taken = taken;
            if (writes)
            begin
                exp_wb_valid = 1'b1;
                exp_wb_addr  = instr.r.rd;
                exp_wb_data  = res;
                if (instr.r.rd < NUM_REGS)
                    regs[instr.r.rd] = res;
            end
        end
    end

    // ------------------------------------------------------------------------
    // compare at the falling edge where the outputs are settled
    // ------------------------------------------------------------------------
    always @(negedge clock)
    begin
        if (armed)
        begin
            if (wb_valid === 1'b1)
                n_wb++;
            if (wb_valid !== exp_wb_valid)
            begin
                n_pulse++;
                if (exp_wb_valid)
                    $display("missing write-back pulse at %0t ns", $time);
                else
                    $display("write-back pulse at %0t ns where none was expected", $time);
            end
            else if (exp_wb_valid)
            begin
                if (wb_addr !== exp_wb_addr)
                begin
                    n_value++;
                    $display("CHECK FAILED wb_addr expected %h actual %h", exp_wb_addr, wb_addr);
                end
                if (wb_data !== exp_wb_data)
                begin
                    n_value++;
                    $display("CHECK FAILED wb_data expected %h actual %h", exp_wb_data, wb_data);
                end
            end
            if (branch_taken !== exp_taken)
            begin
                n_pulse++;
                $display("branch_taken was %b at %0t ns but the model says %b",
                         branch_taken, $time, exp_taken);
            end
            if (cond_flag !== flag)
            begin
                n_value++;
                $display("CHECK FAILED cond_flag expected %h actual %h", flag, cond_flag);
            end
            if (pc !== model_pc)
            begin
                n_value++;
                $display("CHECK FAILED pc expected %h actual %h", model_pc, pc);
            end
        end
    end

endmodule

/* dv/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb
    import exu_pkg::*;
();

    localparam int NUM_REGS    = 16;
    localparam int LINK_REG    = 8;
    localparam int NUM_INSTR   = 2000;
    localparam int CLK_PERIOD  = 100;
    localparam int WATCHDOG_NS = (NUM_INSTR + 2 * NUM_REGS + 50) * CLK_PERIOD;

    logic                  clock;
    logic                  arst_n;
    logic                  instr_valid;
    instr_t                instr;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic                  cond_flag;
    logic                  branch_taken;
    logic [DATA_W-1:0]     pc;
    int                    value_errors;
    int                    pulse_errors;
    int                    wb_count;
    integer                seed;

    exu_top #(
        .NUM_REGS (NUM_REGS),
        .LINK_REG (LINK_REG)
    ) i_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .cond_flag    (cond_flag),
        .branch_taken (branch_taken),
        .pc           (pc)
    );

    exu_checker #(
        .NUM_REGS (NUM_REGS),
        .LINK_REG (LINK_REG)
    ) i_checker (
        .clock        (clock),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .cond_flag    (cond_flag),
        .branch_taken (branch_taken),
        .pc           (pc),
        .value_errors (value_errors),
        .pulse_errors (pulse_errors),
        .wb_count     (wb_count)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // drives one instruction slot that the DUT samples at the following edge
    task automatic drive(input logic valid, input instr_t word);
        @(posedge clock);
        instr_valid <= valid;
        instr       <= word;
    endtask

    function automatic instr_t make_instr(input logic [OPCODE_W-1:0] op,
                                          input logic [REG_ADDR_W-1:0] rd,
                                          input logic [REG_ADDR_W-1:0] ra,
                                          input logic [IMM_W-1:0] imm);
        instr_t word;

        word          = '0;
        word.i.imm    = imm;
        word.i.opcode = op;
        word.i.rd     = rd;
        word.i.ra     = ra;
        return word;
    endfunction

    task automatic preload_regs();
        for (int r = 0; r < NUM_REGS; r++)
        begin
            drive(1'b1, make_instr(OP_LDH, REG_ADDR_W'(r), REG_ADDR_W'(r),
                                   IMM_W'($random(seed))));
            drive(1'b1, make_instr(OP_LDL, REG_ADDR_W'(r), REG_ADDR_W'(r),
                                   IMM_W'($random(seed))));
        end
    endtask

    task automatic run_random(input int count);
        instr_t     word;
        logic [3:0] op;
        logic       valid;

        for (int n = 0; n < count; n++)
        begin
            word          = instr_t'($random(seed));
            op            = 4'($random(seed));
            word.r.opcode = {3'b000, op};             // opcodes 0 to 15 including the reserved ones
            valid         = (($random(seed) & 3) != 0);   // about three in four slots carry work
            drive(valid, word);
        end
    endtask

    initial
    begin
        seed        = 90255;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (10) @(posedge clock);
        arst_n <= 1'b1;

        drive(1'b1, make_instr(OP_MOV, 4'd3, 4'd5, '0));   // register still clear from reset
        preload_regs();
        run_random(NUM_INSTR);
        drive(1'b0, '0);
        repeat (3) @(posedge clock);

        $display("value errors %0d, pulse errors %0d, write-backs seen %0d",
                 value_errors, pulse_errors, wb_count);
        if ((value_errors == 0) && (pulse_errors == 0) && (wb_count > 0))
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the stimulus did not complete", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
src/exu_pkg.sv
src/ripple_adder.sv
src/alu.sv
src/branch_unit.sv
src/reg_file.sv
src/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - files:
      - src/exu_pkg.sv
      - src/ripple_adder.sv
      - src/alu.sv
      - src/branch_unit.sv
      - src/reg_file.sv
      - src/exu_top.sv

  - target: simulation
    files:
      - dv/exu_checker.sv
      - dv/exu_tb.sv
